// File: logic/mem_pkg.sv
`default_nettype none

package mem_pkg;

  localparam int xlen = 32;
  localparam int reg_addr_width = 5;
  localparam int dtim_depth_log2 = 10; // 1k words
  localparam int dtim_wait = 2;

  typedef enum logic [2:0] {
    op_none,
    op_alu,
    op_load,
    op_store,
    op_fence
  } mem_op_t;

  typedef enum logic [1:0] {
    lsu_byte,
    lsu_half,
    lsu_word
  } lsu_width_t;

  // narrow store data copied to every lane of the word
  function automatic logic [xlen-1:0] store_data(input logic [xlen-1:0] sdata,
                                                 input lsu_width_t width);
    logic [xlen-1:0] result;
    case (width)
      lsu_byte: result = {4{sdata[7:0]}};
      lsu_half: result = {2{sdata[15:0]}};
      default:  result = sdata;
    endcase
    return result;
  endfunction

  function automatic logic [xlen/8-1:0] byte_enable(input lsu_width_t width,
                                                    input logic [1:0] offset);
    logic [xlen/8-1:0] strobe;
    case (width)
      lsu_byte: strobe = 4'b0001 << offset;
      lsu_half: strobe = 4'b0011 << {offset[1], 1'b0}; // bit 0 dropped
      default:  strobe = 4'b1111;
    endcase
    return strobe;
  endfunction

endpackage

`default_nettype wire

// File: logic/load_align.sv
`timescale 1ns/1ps
`default_nettype none

module load_align import mem_pkg::*; (
  input  logic [xlen-1:0] rdata,
  input  lsu_width_t      lsu_width,
  input  logic            lsu_unsigned,
  input  logic [1:0]      lsu_offset,
  output logic [xlen-1:0] ldata
);

  logic [xlen-1:0] shifted;
  logic            sign_bit;

  // addressed byte moved down to bit 0
  assign shifted = rdata >> {lsu_offset, 3'b000};

  always_comb begin
    sign_bit = 1'b0;
    case (lsu_width)
      lsu_byte: begin
        sign_bit = shifted[7] & ~lsu_unsigned;
        ldata = {{(xlen-8){sign_bit}}, shifted[7:0]};
      end
      lsu_half: begin
        sign_bit = shifted[15] & ~lsu_unsigned;
        ldata = {{(xlen-16){sign_bit}}, shifted[15:0]};
      end
      default: begin
        ldata = rdata; // full word, no shift
      end
    endcase
  end

endmodule

`default_nettype wire

// File: logic/dtim.sv
`timescale 1ns/1ps
`default_nettype none

module dtim import mem_pkg::*; (
  input  logic                clock,
  input  logic                reset,
  input  logic                mem_valid,
  input  logic                mem_fence,
  input  logic [xlen-1:0]     mem_addr,
  input  logic [xlen-1:0]     mem_wdata,
  input  logic [xlen/8-1:0]   mem_wstrb,
  output logic                mem_ready,
  output logic [xlen-1:0]     mem_rdata
);

  logic [xlen-1:0] ram [0:(1 << dtim_depth_log2)-1];

  logic [$clog2(dtim_wait+1)-1:0] wait_count;
  logic [dtim_depth_log2-1:0]     word_addr;
  logic                           mem_write;

  assign word_addr = mem_addr[dtim_depth_log2+1:2];

  // ready once the wait states have run out
  assign mem_ready = mem_valid & (wait_count == dtim_wait);

  assign mem_write = mem_ready & ~mem_fence & (|mem_wstrb);

  always_ff @(posedge clock) begin
    if (!reset) begin
      wait_count <= '0;
    end else if (!mem_valid || mem_ready) begin
      wait_count <= '0; // rearm for the next request
    end else begin
      wait_count <= wait_count + 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (mem_write) begin
      for (int i = 0; i < xlen/8; i++) begin
        if (mem_wstrb[i]) begin
          ram[word_addr][8*i +: 8] <= mem_wdata[8*i +: 8];
        end
      end
    end
  end

  // address is held through the wait states, so the
  // registered word is current by the ready cycle
  always_ff @(posedge clock) begin
    if (mem_valid && !mem_fence) begin
      mem_rdata <= ram[word_addr];
    end
  end

endmodule

`default_nettype wire

// File: logic/memory_stage.sv
`timescale 1ns/1ps
`default_nettype none

module memory_stage import mem_pkg::*; (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      flush,
  input  mem_op_t                   ex0_op,
  input  lsu_width_t                ex0_width,
  input  logic                      ex0_unsigned,
  input  logic [xlen-1:0]           ex0_addr,
  input  logic [xlen-1:0]           ex0_sdata,
  input  logic [reg_addr_width-1:0] ex0_waddr,
  input  logic [xlen-1:0]           ex0_wdata,
  input  logic                      ex1_valid,
  input  logic [reg_addr_width-1:0] ex1_waddr,
  input  logic [xlen-1:0]           ex1_wdata,
  input  logic                      mem_ready,
  input  logic [xlen-1:0]           ldata,
  output logic                      mem_valid,
  output logic                      mem_fence,
  output logic [xlen-1:0]           mem_addr,
  output logic [xlen-1:0]           mem_wdata,
  output logic [xlen/8-1:0]         mem_wstrb,
  output lsu_width_t                lsu_width,
  output logic                      lsu_unsigned,
  output logic [1:0]                lsu_offset,
  output logic                      stall,
  output logic                      fwd0_wren,
  output logic [reg_addr_width-1:0] fwd0_waddr,
  output logic [xlen-1:0]           fwd0_wdata,
  output logic                      fwd1_wren,
  output logic [reg_addr_width-1:0] fwd1_waddr,
  output logic [xlen-1:0]           fwd1_wdata,
  output logic                      wb0_wren,
  output logic [reg_addr_width-1:0] wb0_waddr,
  output logic [xlen-1:0]           wb0_wdata,
  output logic                      wb1_wren,
  output logic [reg_addr_width-1:0] wb1_waddr,
  output logic [xlen-1:0]           wb1_wdata
);

  // stage register, lane 0
  mem_op_t                   s0_op;
  lsu_width_t                s0_width;
  logic                      s0_unsigned;
  logic [xlen-1:0]           s0_addr;
  logic [xlen-1:0]           s0_sdata;
  logic [reg_addr_width-1:0] s0_waddr;
  logic [xlen-1:0]           s0_wdata;

  // stage register, lane 1
  logic                      s1_valid;
  logic [reg_addr_width-1:0] s1_waddr;
  logic [xlen-1:0]           s1_wdata;

  logic mem_wait;

  always_ff @(posedge clock) begin
    if (!reset || flush) begin
      s0_op    <= op_none;
      s1_valid <= 1'b0;
    end else if (!stall) begin
      s0_op    <= ex0_op;
      s1_valid <= ex1_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (!stall) begin
      s0_width    <= ex0_width;
      s0_unsigned <= ex0_unsigned;
      s0_addr     <= ex0_addr;
      s0_sdata    <= ex0_sdata;
      s0_waddr    <= ex0_waddr;
      s0_wdata    <= ex0_wdata;
      s1_waddr    <= ex1_waddr;
      s1_wdata    <= ex1_wdata;
    end
  end

  assign mem_valid = (s0_op == op_load) | (s0_op == op_store) | (s0_op == op_fence);
  assign mem_fence = (s0_op == op_fence);
  assign mem_addr  = s0_addr;
  assign mem_wdata = store_data(s0_sdata, s0_width);
  assign mem_wstrb = (s0_op == op_store) ? byte_enable(s0_width, s0_addr[1:0]) : '0;

  assign lsu_width    = s0_width;
  assign lsu_unsigned = s0_unsigned;
  assign lsu_offset   = s0_addr[1:0];

  assign mem_wait = mem_valid & ~mem_ready;
  assign stall    = mem_wait & ~flush; // flush wins

  // both lanes write only once the stage can move on
  assign fwd0_wren  = ((s0_op == op_alu) | (s0_op == op_load)) & ~mem_wait & ~flush;
  assign fwd0_waddr = s0_waddr;
  assign fwd0_wdata = (s0_op == op_load) ? ldata : s0_wdata;

  assign fwd1_wren  = s1_valid & ~mem_wait & ~flush;
  assign fwd1_waddr = s1_waddr;
  assign fwd1_wdata = s1_wdata;

  always_ff @(posedge clock) begin
    if (!reset || flush) begin
      wb0_wren <= 1'b0;
      wb1_wren <= 1'b0;
    end else begin
      wb0_wren <= fwd0_wren; // null while stalled
      wb1_wren <= fwd1_wren;
    end
  end

  always_ff @(posedge clock) begin
    wb0_waddr <= fwd0_waddr;
    wb0_wdata <= fwd0_wdata;
    wb1_waddr <= fwd1_waddr;
    wb1_wdata <= fwd1_wdata;
  end

endmodule

`default_nettype wire

// File: logic/mem_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem import mem_pkg::*; (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      flush,
  input  mem_op_t                   ex0_op,
  input  lsu_width_t                ex0_width,
  input  logic                      ex0_unsigned,
  input  logic [xlen-1:0]           ex0_addr,
  input  logic [xlen-1:0]           ex0_sdata,
  input  logic [reg_addr_width-1:0] ex0_waddr,
  input  logic [xlen-1:0]           ex0_wdata,
  input  logic                      ex1_valid,
  input  logic [reg_addr_width-1:0] ex1_waddr,
  input  logic [xlen-1:0]           ex1_wdata,
  output logic                      stall,
  output logic                      fwd0_wren,
  output logic [reg_addr_width-1:0] fwd0_waddr,
  output logic [xlen-1:0]           fwd0_wdata,
  output logic                      fwd1_wren,
  output logic [reg_addr_width-1:0] fwd1_waddr,
  output logic [xlen-1:0]           fwd1_wdata,
  output logic                      wb0_wren,
  output logic [reg_addr_width-1:0] wb0_waddr,
  output logic [xlen-1:0]           wb0_wdata,
  output logic                      wb1_wren,
  output logic [reg_addr_width-1:0] wb1_waddr,
  output logic [xlen-1:0]           wb1_wdata
);

  logic              mem_valid;
  logic              mem_fence;
  logic [xlen-1:0]   mem_addr;
  logic [xlen-1:0]   mem_wdata;
  logic [xlen/8-1:0] mem_wstrb;
  logic              mem_ready;
  logic [xlen-1:0]   mem_rdata;
  lsu_width_t        lsu_width;
  logic              lsu_unsigned;
  logic [1:0]        lsu_offset;
  logic [xlen-1:0]   ldata;

  memory_stage u_memory_stage (.*);

  load_align u_load_align (
    .rdata        (mem_rdata),
    .lsu_width    (lsu_width),
    .lsu_unsigned (lsu_unsigned),
    .lsu_offset   (lsu_offset),
    .ldata        (ldata)
  );

  dtim u_dtim (.*);

endmodule

`default_nettype wire

// File: sim/tb_mem_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsystem import mem_pkg::*; ();

  logic                      clock;
  logic                      reset;
  logic                      flush;
  mem_op_t                   ex0_op;
  lsu_width_t                ex0_width;
  logic                      ex0_unsigned;
  logic [xlen-1:0]           ex0_addr;
  logic [xlen-1:0]           ex0_sdata;
  logic [reg_addr_width-1:0] ex0_waddr;
  logic [xlen-1:0]           ex0_wdata;
  logic                      ex1_valid;
  logic [reg_addr_width-1:0] ex1_waddr;
  logic [xlen-1:0]           ex1_wdata;
  logic                      stall;
  logic                      fwd0_wren;
  logic [reg_addr_width-1:0] fwd0_waddr;
  logic [xlen-1:0]           fwd0_wdata;
  logic                      fwd1_wren;
  logic [reg_addr_width-1:0] fwd1_waddr;
  logic [xlen-1:0]           fwd1_wdata;
  logic                      wb0_wren;
  logic [reg_addr_width-1:0] wb0_waddr;
  logic [xlen-1:0]           wb0_wdata;
  logic                      wb1_wren;
  logic [reg_addr_width-1:0] wb1_waddr;
  logic [xlen-1:0]           wb1_wdata;

  logic [7:0]                ref_mem [0:4095]; // byte image of the dtim
  int                        seed;
  int                        errors;
  int                        checks;
  logic [xlen-1:0]           last_addr;
  logic                      seen0_wren; // wb lanes as seen by finish_op
  logic [reg_addr_width-1:0] seen0_waddr;
  logic [xlen-1:0]           seen0_wdata;
  logic                      seen1_wren;
  logic [xlen-1:0]           seen1_wdata;

  mem_subsystem u_mem_subsystem (.*);

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  task automatic check_value(input string name, input logic [xlen-1:0] got,
                             input logic [xlen-1:0] expected);
    checks++;
    assert (got === expected) else begin
      errors++;
      $display("Error: %s is %h, expected %h", name, got, expected);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond === 1'b1) else begin
      errors++;
      $display("%s", what);
    end
  endtask

  task automatic drive_idle();
    ex0_op       = op_none;
    ex0_width    = lsu_word;
    ex0_unsigned = 1'b0;
    ex0_addr     = '0;
    ex0_sdata    = '0;
    ex0_waddr    = '0;
    ex0_wdata    = '0;
    ex1_valid    = 1'b0;
    ex1_waddr    = '0;
    ex1_wdata    = '0;
  endtask

  // hold the ex inputs until an edge with stall low takes them
  task automatic issue_and_capture();
    int n;
    n = 0;
    @(negedge clock);
    while (stall && n < 20) begin
      @(negedge clock);
      n++;
    end
    check_true(n < 20, "timeout waiting for the stage to take an instruction");
    @(posedge clock);
    #5;
    drive_idle();
  endtask

  task automatic finish_op(output int stalls);
    int n;
    stalls = 0;
    n = 0;
    @(negedge clock);
    while (stall && stalls < 20) begin
      stalls++;
      @(negedge clock);
    end
    check_true(stalls < 20, "timeout waiting for stall to drop");
    while (!(wb0_wren || wb1_wren) && n < 4) begin
      @(negedge clock);
      n++;
    end
    seen0_wren  = wb0_wren;
    seen0_waddr = wb0_waddr;
    seen0_wdata = wb0_wdata;
    seen1_wren  = wb1_wren;
    seen1_wdata = wb1_wdata;
    @(posedge clock);
    #5;
  endtask

  task automatic run_op(input mem_op_t op, input lsu_width_t width, input logic uns,
                        input logic [xlen-1:0] addr, input logic [xlen-1:0] sdata,
                        input logic [reg_addr_width-1:0] waddr, output int stalls);
    ex0_op       = op;
    ex0_width    = width;
    ex0_unsigned = uns;
    ex0_addr     = addr;
    ex0_sdata    = sdata;
    ex0_waddr    = waddr;
    issue_and_capture();
    finish_op(stalls);
  endtask

  task automatic model_store(input lsu_width_t width, input logic [xlen-1:0] addr,
                             input logic [xlen-1:0] sdata);
    int a;
    a = int'(addr[11:0]);
    case (width)
      lsu_byte: ref_mem[a] = sdata[7:0];
      lsu_half: begin
        a = a & ~1; // low bit ignored by the strobes
        ref_mem[a]     = sdata[7:0];
        ref_mem[a + 1] = sdata[15:8];
      end
      default: begin
        a = a & ~3;
        for (int i = 0; i < 4; i++) ref_mem[a + i] = sdata[8*i +: 8];
      end
    endcase
  endtask

  function automatic logic [xlen-1:0] model_load(input lsu_width_t width, input logic uns,
                                                 input logic [xlen-1:0] addr);
    int              a;
    logic [xlen-1:0] word;
    a = int'(addr[11:0]);
    case (width)
      lsu_byte: word = uns ? {24'h0, ref_mem[a]} : {{24{ref_mem[a][7]}}, ref_mem[a]};
      lsu_half: begin
        a = a & ~1;
        word = {16'h0, ref_mem[a + 1], ref_mem[a]};
        if (!uns) word[31:16] = {16{word[15]}};
      end
      default: begin
        a = a & ~3;
        word = {ref_mem[a + 3], ref_mem[a + 2], ref_mem[a + 1], ref_mem[a]};
      end
    endcase
    return word;
  endfunction

  task automatic do_store(input lsu_width_t width, input logic [xlen-1:0] addr,
                          input logic [xlen-1:0] sdata);
    int stalls;
    run_op(op_store, width, 1'b0, addr, sdata, '0, stalls);
    model_store(width, addr, sdata);
    check_value("stall count", stalls, dtim_wait);
    check_true(!seen0_wren, "a store produced a wb0 write");
  endtask

  task automatic do_load(input lsu_width_t width, input logic uns,
                         input logic [xlen-1:0] addr, input logic [reg_addr_width-1:0] waddr);
    int stalls;
    run_op(op_load, width, uns, addr, '0, waddr, stalls);
    check_value("stall count", stalls, dtim_wait);
    check_true(seen0_wren, "no wb0 write for a load");
    check_value("wb0_waddr", seen0_waddr, waddr);
    check_value("wb0_wdata", seen0_wdata, model_load(width, uns, addr));
  endtask

  task automatic test_reset_idle();
    for (int n = 0; n < 4; n++) begin
      @(negedge clock);
      check_value("stall", stall, 0);
      check_value("fwd0_wren", fwd0_wren, 0);
      check_value("fwd1_wren", fwd1_wren, 0);
      check_value("wb0_wren", wb0_wren, 0);
      check_value("wb1_wren", wb1_wren, 0);
    end
    @(posedge clock);
    #5;
  endtask

  task automatic test_word_access();
    logic [xlen-1:0] addr;
    for (int i = 0; i < 4; i++) begin
      addr = $random(seed) & 32'hffc;
      do_store(lsu_word, addr, $random(seed));
      do_load(lsu_word, 1'b0, addr, 5'd1);
      last_addr = addr;
    end
  endtask

  task automatic test_narrow_access();
    logic [xlen-1:0] base;
    logic [xlen-1:0] mask_or;
    logic [xlen-1:0] mask_and;
    for (int r = 0; r < 2; r++) begin
      mask_or  = (r == 0) ? 32'h8080_8080 : 32'h0; // negative bytes first round
      mask_and = (r == 0) ? 32'hffff_ffff : 32'h7f7f_7f7f;
      base = $random(seed) & 32'hffc;
      do_store(lsu_word, base, $random(seed));
      for (int off = 0; off < 4; off++) begin
        do_store(lsu_byte, base + off, ($random(seed) | mask_or) & mask_and);
      end
      do_load(lsu_word, 1'b0, base, 5'd2);
      for (int off = 0; off < 4; off++) begin
        do_load(lsu_byte, 1'b0, base + off, 5'd2);
        do_load(lsu_byte, 1'b1, base + off, 5'd2);
      end
      for (int off = 0; off < 4; off += 2) begin
        do_store(lsu_half, base + off, ($random(seed) | mask_or) & mask_and);
        do_load(lsu_half, 1'b0, base + off, 5'd3);
        do_load(lsu_half, 1'b1, base + off, 5'd3);
      end
      do_load(lsu_word, 1'b0, base, 5'd2);
    end
  endtask

  task automatic test_alu_lanes();
    logic [xlen-1:0] d0;
    logic [xlen-1:0] d1;
    int              stalls;
    d0 = $random(seed);
    d1 = $random(seed);
    ex0_op    = op_alu;
    ex0_waddr = 5'd3;
    ex0_wdata = d0;
    ex1_valid = 1'b1;
    ex1_waddr = 5'd7;
    ex1_wdata = d1;
    issue_and_capture();
    @(negedge clock); // cycle after capture
    check_value("fwd0_wren", fwd0_wren, 1);
    check_value("fwd0_waddr", fwd0_waddr, 5'd3);
    check_value("fwd0_wdata", fwd0_wdata, d0);
    check_value("fwd1_wren", fwd1_wren, 1);
    check_value("fwd1_waddr", fwd1_waddr, 5'd7);
    check_value("fwd1_wdata", fwd1_wdata, d1);
    check_value("wb0_wren", wb0_wren, 0);
    @(negedge clock);
    check_value("wb0_wren", wb0_wren, 1);
    check_value("wb0_waddr", wb0_waddr, 5'd3);
    check_value("wb0_wdata", wb0_wdata, d0);
    check_value("wb1_wren", wb1_wren, 1);
    check_value("wb1_waddr", wb1_waddr, 5'd7);
    check_value("wb1_wdata", wb1_wdata, d1);
    @(posedge clock);
    #5;
    // lane 1 rides along with a load and waits for it
    d1 = $random(seed);
    ex1_valid = 1'b1;
    ex1_waddr = 5'd9;
    ex1_wdata = d1;
    run_op(op_load, lsu_word, 1'b0, last_addr, '0, 5'd4, stalls);
    check_value("stall count", stalls, dtim_wait);
    check_true(seen0_wren && seen1_wren, "lane 1 and the load did not write back together");
    check_value("wb1_wdata", seen1_wdata, d1);
    check_value("wb0_wdata", seen0_wdata, model_load(lsu_word, 1'b0, last_addr));
  endtask

  task automatic test_fence();
    int stalls;
    run_op(op_fence, lsu_word, 1'b0, last_addr, '0, 5'd5, stalls);
    check_value("stall count", stalls, dtim_wait);
    check_true(!seen0_wren, "a fence produced a wb0 write");
    do_load(lsu_word, 1'b0, last_addr, 5'd6);
  endtask

  task automatic test_flush();
    logic hit;
    hit = 1'b0;
    ex0_op    = op_load;
    ex0_width = lsu_word;
    ex0_addr  = last_addr;
    ex0_waddr = 5'd8;
    issue_and_capture();
    @(negedge clock);
    check_value("stall", stall, 1);
    @(posedge clock);
    #5;
    flush = 1'b1;
    @(negedge clock);
    check_value("stall", stall, 0); // flush overrides the wait
    check_value("fwd0_wren", fwd0_wren, 0);
    @(posedge clock);
    #5;
    flush = 1'b0;
    for (int n = 0; n < 6; n++) begin
      @(negedge clock);
      if (wb0_wren) hit = 1'b1;
    end
    check_true(!hit, "the flushed load reached writeback");
    @(posedge clock);
    #5;
    do_load(lsu_word, 1'b0, last_addr, 5'd10);
  endtask

  initial begin
    seed = 34;
    errors = 0;
    checks = 0;
    last_addr = '0;
    reset = 1'b0;
    flush = 1'b0;
    drive_idle();
    repeat (8) @(posedge clock);
    #5;
    reset = 1'b1;
    test_reset_idle();
    test_word_access();
    test_narrow_access();
    test_alu_lanes();
    test_fence();
    test_flush();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
logic/mem_pkg.sv
logic/load_align.sv
logic/dtim.sv
logic/memory_stage.sv
logic/mem_subsystem.sv
sim/tb_mem_subsystem.sv

// File: Makefile
SIM := obj_dir/Vtb_mem_subsystem
SRC := $(shell cat compile.f)

all: run

$(SIM): compile.f $(SRC)
	verilator --binary --timing -Wno-fatal -f compile.f --top-module tb_mem_subsystem

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -qx "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
